// File: project.f
alu_pkg.sv
trig_pkg.sv
alu_core.sv
alu_flags_stage.sv
r1_pattern_gen.sv
trigger_detector.sv
alu_host_top.sv
tb_alu_host_asserts.sv
tb_alu_host.sv

// File: Makefile
# Verilator simulation of the ALU host testbench

VERILATOR ?= verilator
SIM_TOP   ?= tb_alu_host
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(SIM_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_alu_host.sv
// --------------------
// Testbench for the two-stage ALU host with
// random stimulus and a reference model of the trigger path
// --------------------
`timescale 1ns/10ps

module tb_alu_host
    import alu_pkg::*;
();

    localparam int          num_slots  = 3000;
    localparam int          max_cycles = num_slots + 500;  // Slots, resets and drain
    localparam logic [15:0] r1_seed    = 16'hB00B;
    localparam logic [3:0]  trig_seq   = 4'b1011;
    localparam logic [15:0] flip_mask  = 16'h000F;

    typedef struct packed {
        logic [15:0] result;
        alu_flags_t  flags;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        op_strobe;
    alu_req_t    req;
    logic        out_valid;
    logic [15:0] result;
    alu_flags_t  flags;

    expect_t     exp_q[$];
    expect_t     want;
    expect_t     got;
    logic [15:0] m_lfsr;  // Model copies of the pattern state
    logic [3:0]  m_count;
    logic [3:0]  m_hist;
    int          tamper_hits;
    int          cycle_count;

    alu_host_top DUT (
        .clk       (clk),
        .rst       (rst),
        .op_strobe (op_strobe),
        .req       (req),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Expected ALU output from the op rules, before any tamper
    function automatic expect_t model_alu(input alu_req_t r);
        expect_t e;
        int      ua;
        int      ub;
        int      sa;
        int      sb;
        int      wide;
        ua = r.operand_a;
        ub = r.operand_b;
        sa = $signed(r.operand_a);
        sb = $signed(r.operand_b);
        e  = '0;
        case (r.op)
            ADD: begin
                wide             = ua + ub;
                e.result         = wide[15:0];
                e.flags.carry    = (wide > 65535);
                e.flags.overflow = (sa + sb > 32767) || (sa + sb < -32768);
            end
            SUB: begin
                wide             = ua - ub;
                e.result         = wide[15:0];
                e.flags.carry    = (ua < ub);  // Borrow
                e.flags.overflow = (sa - sb > 32767) || (sa - sb < -32768);
            end
            AND: e.result = r.operand_a & r.operand_b;
            OR:  e.result = r.operand_a | r.operand_b;
            XOR: e.result = r.operand_a ^ r.operand_b;
            NOT: e.result = ~r.operand_a;
            SHL: begin
                e.result      = {r.operand_a[14:0], 1'b0};
                e.flags.carry = r.operand_a[15];
            end
            SHR: e.result = {1'b0, r.operand_a[15:1]};
            SLT: e.result = (ua < ub) ? 16'd1 : 16'd0;
            SEQ: e.result = (ua == ub) ? 16'd1 : 16'd0;
            MUL: begin
                wide     = (ua & 255) * (ub & 255);
                e.result = wide[15:0];
            end
            default: e.result = '0;
        endcase
        e.flags.zero     = (e.result == 16'h0000);
        e.flags.negative = e.result[15];
        return e;
    endfunction

    // Corner values about half of the time
    function automatic logic [15:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return 16'h0000;
            1:       return 16'hFFFF;
            2:       return 16'h8000;
            3:       return 16'h7FFF;
            default: return 16'($urandom_range(0, 65535));
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic run_slot();
        logic [3:0] code;
        @(posedge clk);
        #5;
        code          = 4'($urandom_range(0, 15));  // Includes undefined codes
        op_strobe     = ($urandom_range(0, 99) < 70);
        req.op        = alu_op_e'(code);
        req.operand_a = pick_operand();
        req.operand_b = pick_operand();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
            op_strobe = 1'b0;
        end
    endtask

    task automatic apply_reset(input int n);
        @(posedge clk);
        #5;
        op_strobe = 1'b0;
        rst       = 1'b1;
        repeat (n) @(posedge clk);
        #5;
        rst = 1'b0;
    endtask

    // Mirror of counter, LFSR and history
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_lfsr  = r1_seed;
            m_count = 4'd0;
            m_hist  = 4'd0;
            exp_q.delete();  // Pipeline is cleared too
        end else begin
            m_hist = {m_hist[2:0], m_lfsr[m_count]};
            if (op_strobe) begin
                want = model_alu(req);
                if (m_hist == trig_seq) begin
                    want.result = want.result ^ flip_mask;  // Flags stay untampered
                    tamper_hits++;
                end
                exp_q.push_back(want);
                if (m_count == 4'hF) begin
                    m_lfsr = {m_lfsr[14:0], m_lfsr[15] ^ m_lfsr[13] ^ m_lfsr[12] ^ m_lfsr[10]};
                end
                m_count = m_count + 4'd1;
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid was high with no operation outstanding");
                $display("TB FAILED");
                $fatal(1);
            end else begin
                got = exp_q.pop_front();
                check_value("result", got.result, result);
                check_value("flags", 16'(got.flags), 16'(flags));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Run did not finish within %0d cycles", max_cycles);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(61499));
        rst         = 1'b1;
        op_strobe   = 1'b0;
        req         = '0;
        tamper_hits = 0;
        cycle_count = 0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        for (int slot = 0; slot < num_slots; slot++) begin
            if (slot == num_slots / 2) begin
                idle_cycles(3);  // Drain before the second reset
                apply_reset(3);
            end
            run_slot();
        end
        idle_cycles(1);

        while (exp_q.size() != 0) @(posedge clk);
        idle_cycles(4);

        if (tamper_hits >= 3) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Trigger sequence was seen too rarely to reach the tamper path");
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

// File: tb_alu_host_asserts.sv
// --------------------
// Bound checks on strobe timing and reset state
// --------------------
`timescale 1ns/10ps

module tb_alu_host_asserts
    import alu_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  op_strobe,
    input logic                  stage_valid,
    input logic                  out_valid,
    input logic [data_width-1:0] result,
    input alu_flags_t            flags
);

    logic outputs_seen;  // First out_valid since reset

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outputs_seen <= 1'b0;
        end else if (out_valid) begin
            outputs_seen <= 1'b1;
        end
    end

    stage_follows: assert property (@(posedge clk) disable iff (rst)
        op_strobe |=> stage_valid)
        else $error("stage_valid did not follow op_strobe by one cycle");

    out_two_after: assert property (@(posedge clk) disable iff (rst)
        op_strobe |-> ##2 out_valid)
        else $error("out_valid did not rise two cycles after op_strobe");

    out_needs_strobe: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(op_strobe, 2))
        else $error("out_valid rose without an op_strobe two cycles before");

    // Two strobes in a row keep two operations in flight
    back_to_back: assert property (@(posedge clk) disable iff (rst)
        op_strobe ##1 op_strobe |-> ##1 out_valid ##1 out_valid)
        else $error("back-to-back strobes did not give back-to-back outputs");

    reset_clean: assert property (@(posedge clk)
        $fell(rst) |-> !out_valid && result == '0 && flags == '0)
        else $error("outputs were not cleared by reset");

    quiet_until_output: assert property (@(posedge clk) disable iff (rst)
        !outputs_seen && !out_valid |-> result == '0 && flags == '0)
        else $error("result or flags changed before the first output");

endmodule

bind alu_host_top tb_alu_host_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .op_strobe   (op_strobe),
    .stage_valid (stage_valid),
    .out_valid   (out_valid),
    .result      (result),
    .flags       (flags)
);

// File: alu_host_top.sv
// --------------------
// Two-stage ALU host with the r1 trigger path
// --------------------
`timescale 1ns/10ps

module alu_host_top
    import alu_pkg::*, trig_pkg::*;
#(
    parameter logic [15:0] R1_PATTERN = r1_pattern_default,
    parameter trig_hist_t  TRIG_SEQ   = trig_seq_default
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  op_strobe,
    input  alu_req_t              req,
    output logic                  out_valid,
    output logic [data_width-1:0] result,
    output alu_flags_t            flags
);

    logic       stage_valid;
    alu_stage_t stage;
    logic       r1;
    logic       trigger;

    alu_core u_alu_core (
        .clk         (clk),
        .rst         (rst),
        .op_strobe   (op_strobe),
        .req         (req),
        .stage_valid (stage_valid),
        .stage       (stage)
    );

    alu_flags_stage u_alu_flags_stage (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .stage       (stage),
        .trigger     (trigger),
        .out_valid   (out_valid),
        .result      (result),
        .flags       (flags)
    );

    r1_pattern_gen #(
        .R1_PATTERN (R1_PATTERN)
    ) u_r1_pattern_gen (
        .clk       (clk),
        .rst       (rst),
        .op_strobe (op_strobe),
        .r1        (r1)
    );

    // Watches r1 on every clock
    trigger_detector #(
        .TRIG_SEQ (TRIG_SEQ)
    ) u_trigger_detector (
        .clk     (clk),
        .rst     (rst),
        .r1      (r1),
        .trigger (trigger)
    );

endmodule

// File: trigger_detector.sv
// --------------------
// Matches recent r1 history against the trigger sequence
// --------------------
`timescale 1ns/10ps

module trigger_detector
    import trig_pkg::*;
#(
    parameter trig_hist_t TRIG_SEQ = trig_seq_default
) (
    input  logic clk,
    input  logic rst,
    input  logic r1,
    output logic trigger
);

    trig_hist_t hist;

    // Shifts every clock, strobe or not
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist <= '0;
        end else begin
            hist <= {hist[2:0], r1};  // Newest bit at LSB
        end
    end

    assign trigger = (hist == TRIG_SEQ);

endmodule

// File: r1_pattern_gen.sv
// --------------------
// LFSR indexed by a strobe counter to form r1
// --------------------
`timescale 1ns/10ps

module r1_pattern_gen
    import trig_pkg::*;
#(
    parameter logic [15:0] R1_PATTERN = r1_pattern_default
) (
    input  logic clk,
    input  logic rst,
    input  logic op_strobe,
    output logic r1
);

    logic [15:0] lfsr;
    logic [3:0]  count;
    logic        feedback;

    // Taps 15 13 12 10
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr  <= R1_PATTERN;
            count <= '0;
        end else if (op_strobe) begin
            count <= count + 4'd1;
            // Step once per counter wrap
            if (count == 4'hF) begin
                lfsr <= {lfsr[14:0], feedback};
            end
        end
    end

    assign r1 = lfsr[count];

endmodule

// File: alu_flags_stage.sv
// --------------------
// Second ALU stage that derives flags
// and registers the possibly tampered result
// --------------------
`timescale 1ns/10ps

module alu_flags_stage
    import alu_pkg::*, trig_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stage_valid,
    input  alu_stage_t            stage,
    input  logic                  trigger,
    output logic                  out_valid,
    output logic [data_width-1:0] result,
    output alu_flags_t            flags
);

    logic [data_width-1:0] true_result;
    logic                  sign_a;
    logic                  sign_b;
    logic                  sign_r;
    alu_flags_t            next_flags;

    assign true_result = stage.raw_result[data_width-1:0];
    assign sign_a      = stage.operand_a[data_width-1];
    assign sign_b      = stage.operand_b[data_width-1];
    assign sign_r      = true_result[data_width-1];

    // Flags always describe the untampered result
    always_comb begin
        next_flags.negative = sign_r;
        next_flags.zero     = (true_result == '0);

        case (stage.op)
            ADD, SUB, SHL: next_flags.carry = stage.raw_result[data_width];
            default:       next_flags.carry = 1'b0;
        endcase

        case (stage.op)
            ADD:     next_flags.overflow = (sign_a == sign_b) && (sign_r != sign_a);
            SUB:     next_flags.overflow = (sign_a != sign_b) && (sign_r != sign_a);
            default: next_flags.overflow = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            result    <= '0;
            flags     <= '0;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin
                if (trigger) begin
                    result <= true_result ^ tamper_mask;  // Tamper hit
                end else begin
                    result <= true_result;
                end
                flags <= next_flags;
            end
        end
    end

endmodule

// File: alu_core.sv
// --------------------
// First ALU stage that decodes the op and
// registers the raw result with op and operands
// --------------------
`timescale 1ns/10ps

module alu_core
    import alu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       op_strobe,
    input  alu_req_t   req,
    output logic       stage_valid,
    output alu_stage_t stage
);

    localparam int half_width = data_width / 2;

    logic [data_width:0]   raw;
    logic [data_width-1:0] mul_prod;

    // Low bytes only, full 16-bit product
    assign mul_prod = req.operand_a[half_width-1:0] * req.operand_b[half_width-1:0];

    always_comb begin
        case (req.op)
            ADD: raw = {1'b0, req.operand_a} + {1'b0, req.operand_b};
            SUB: raw = {1'b0, req.operand_a} - {1'b0, req.operand_b};  // Bit 16 is borrow
            AND: raw = {1'b0, req.operand_a & req.operand_b};
            OR:  raw = {1'b0, req.operand_a | req.operand_b};
            XOR: raw = {1'b0, req.operand_a ^ req.operand_b};
            NOT: raw = {1'b0, ~req.operand_a};
            SHL: raw = {req.operand_a, 1'b0};                          // MSB lands in bit 16
            SHR: raw = {2'b00, req.operand_a[data_width-1:1]};
            SLT: raw = {{data_width{1'b0}}, req.operand_a < req.operand_b};
            SEQ: raw = {{data_width{1'b0}}, req.operand_a == req.operand_b};
            MUL: raw = {1'b0, mul_prod};
            default: begin
                raw = '0;  // Undefined codes
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= op_strobe;
        end
    end

    // Op and operands travel along so the flag stage
    // never looks at the live request
    always_ff @(posedge clk) begin
        if (op_strobe) begin
            stage.raw_result <= raw;
            stage.op         <= req.op;
            stage.operand_a  <= req.operand_a;
            stage.operand_b  <= req.operand_b;
        end
    end

endmodule

// File: trig_pkg.sv
// --------------------
// Defaults for the r1 pattern and the trigger path
// --------------------
package trig_pkg;

    // Recent r1 bits, newest at bit 0
    typedef logic [3:0] trig_hist_t;

    localparam logic [15:0] r1_pattern_default = 16'hB00B;  // LFSR seed
    localparam trig_hist_t  trig_seq_default   = 4'b1011;

    // Low result bits flipped while triggered
    localparam logic [15:0] tamper_mask = 16'h000F;

endpackage

// File: alu_pkg.sv
// --------------------
// ALU datapath types with the op encoding and flag layout
// --------------------
package alu_pkg;

    localparam int data_width = 16;  // Operand width

    // Op codes 11 to 15 are undefined and give zero
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        NOT = 4'd5,
        SHL = 4'd6,
        SHR = 4'd7,
        SLT = 4'd8,
        SEQ = 4'd9,
        MUL = 4'd10
    } alu_op_e;

    typedef struct packed {
        logic overflow;  // MSB
        logic carry;
        logic zero;
        logic negative;  // LSB
    } alu_flags_t;

    // Request as seen on the strobe
    typedef struct packed {
        alu_op_e               op;
        logic [data_width-1:0] operand_a;
        logic [data_width-1:0] operand_b;
    } alu_req_t;

    // Between first and second stage
    typedef struct packed {
        logic [data_width:0]   raw_result;  // Bit 16 is carry or borrow
        alu_op_e               op;
        logic [data_width-1:0] operand_a;
        logic [data_width-1:0] operand_b;
    } alu_stage_t;

endpackage
